/* Bender.yml */
package:
  name: pc_sequencer

sources:
  - rtl/pcseq_pkg.sv
  - rtl/pcinc8.sv
  - rtl/opcode_decode.sv
  - rtl/flow_execute.sv
  - rtl/pc_result.sv
  - rtl/pc_sequencer.sv
  - target: simulation
    files:
      - verif/pc_sequencer_tb.sv

/* rtl/flow_execute.sv */
// execute stage; next PC is combinational, traps hold the PC, only the width bits are registered
`timescale 1ns/1ps
`default_nettype none

module flow_execute (
	input wire clk,
	input wire rst,
	input wire d_valid,
	input wire [pcseq_pkg::CLS_W-1:0] d_class,
	input wire [pcseq_pkg::COND_W-1:0] d_cond,
	input wire [pcseq_pkg::INC_W-1:0] d_inc,
	input wire [pcseq_pkg::OPND_W-1:0] d_operand,
	input wire d_flag_n,
	input wire d_flag_v,
	input wire d_flag_z,
	input wire d_flag_c,
	input wire [pcseq_pkg::PC_W-1:0] pc,
	output logic m_bit,
	output logic x_bit,
	output logic [pcseq_pkg::PC_W-1:0] next_pc,
	output logic does_retire,
	output logic does_trap
);

	logic m_reg;
	logic x_reg;
	logic is_mode;
	logic m_next;
	logic x_next;
	logic flag;
	logic taken;
	logic [pcseq_pkg::PC_W-1:0] seq_pc;
	logic [pcseq_pkg::PC_W-1:0] br_off;
	logic [pcseq_pkg::PC_W-1:0] brl_off;

	// ==================================================
	// width mode bits
	// ==================================================

	assign is_mode = d_valid && (d_class == pcseq_pkg::CLS_MODE);
	// d_cond bit 0 is opcode bit 5, high for SEP and low for REP
	assign m_next = d_cond[0] ? (m_reg | d_operand[5]) : (m_reg & ~d_operand[5]);
	assign x_next = d_cond[0] ? (x_reg | d_operand[4]) : (x_reg & ~d_operand[4]);

	// forwarded so that an immediate strobed right behind a SEP or REP sizes correctly
	assign m_bit = is_mode ? m_next : m_reg;
	assign x_bit = is_mode ? x_next : x_reg;

	// both bits come up set, i.e. 8-bit accumulator and index
	always_ff @(posedge clk) begin
		if (rst) begin
			m_reg <= 1'b1;
			x_reg <= 1'b1;
		end else if (is_mode) begin
			m_reg <= m_next;
			x_reg <= x_next;
		end
	end

	// ==================================================
	// branch condition and target
	// ==================================================

	// bits 2:1 pick n, v, c or z and bit 0 is the level that takes the branch
	always_comb begin
		case (d_cond[2:1])
		2'b00: flag = d_flag_n;
		2'b01: flag = d_flag_v;
		2'b10: flag = d_flag_c;
		default: flag = d_flag_z;
		endcase
	end
	assign taken = d_cond[3] || (flag == d_cond[0]);

	assign seq_pc = pc + {{(pcseq_pkg::PC_W - pcseq_pkg::INC_W){1'b0}}, d_inc};
	assign br_off = {{(pcseq_pkg::PC_W - 8){d_operand[7]}}, d_operand[7:0]};
	assign brl_off = {{(pcseq_pkg::PC_W - 16){d_operand[15]}}, d_operand[15:0]};

	always_comb begin
		case (d_class)
		pcseq_pkg::CLS_BRANCH: next_pc = taken ? seq_pc + br_off : seq_pc;
		pcseq_pkg::CLS_BRL: next_pc = seq_pc + brl_off;
		// JMP stays in the current program bank
		pcseq_pkg::CLS_JMP: next_pc = {pc[pcseq_pkg::PC_W-1:16], d_operand[15:0]};
		pcseq_pkg::CLS_JML: next_pc = d_operand[pcseq_pkg::PC_W-1:0];
		pcseq_pkg::CLS_TRAP: next_pc = pc;
		default: next_pc = seq_pc;
		endcase
	end

	assign does_trap = d_valid && (d_class == pcseq_pkg::CLS_TRAP);
	assign does_retire = d_valid && (d_class != pcseq_pkg::CLS_TRAP);

endmodule

`default_nettype wire

/* rtl/opcode_decode.sv */
// decode stage; one instruction per strobe, no back-pressure, registered outputs valid one cycle
`timescale 1ns/1ps
`default_nettype none

module opcode_decode (
	input wire clk,
	input wire rst,
	input wire instr_valid,
	input wire [7:0] opcode,
	input wire [pcseq_pkg::OPND_W-1:0] operand,
	input wire flag_n,
	input wire flag_v,
	input wire flag_z,
	input wire flag_c,
	input wire [3:0] suppress_pcinc,
	input wire m_bit,
	input wire x_bit,
	output logic [pcseq_pkg::INC_W-1:0] inc,
	output logic d_valid,
	output logic [pcseq_pkg::CLS_W-1:0] d_class,
	output logic [pcseq_pkg::COND_W-1:0] d_cond,
	output logic [pcseq_pkg::INC_W-1:0] d_inc,
	output logic [pcseq_pkg::OPND_W-1:0] d_operand,
	output logic d_flag_n,
	output logic d_flag_v,
	output logic d_flag_z,
	output logic d_flag_c
);

	logic [pcseq_pkg::INC_W-1:0] raw_inc;
	logic [pcseq_pkg::CLS_W-1:0] cls;
	logic [pcseq_pkg::COND_W-1:0] cond;

	// the length that goes with the instruction, suppression applied
	pcinc8 u_len (
		.opcode(opcode),
		.suppress_pcinc(suppress_pcinc),
		.m_bit(m_bit),
		.x_bit(x_bit),
		.inc(inc)
	);

	// second lookup without suppression, a zero here marks an opcode the table does not know
	pcinc8 u_len_raw (
		.opcode(opcode),
		.suppress_pcinc(4'hF),
		.m_bit(m_bit),
		.x_bit(x_bit),
		.inc(raw_inc)
	);

	// ==================================================
	// class and condition mapping
	// ==================================================

	always_comb begin
		// opcode bits 7:5 also tell SEP (bit 5 set) from REP for the mode class
		cond = {1'b0, opcode[7:5]};
		case (opcode)
		pcseq_pkg::op_brk, pcseq_pkg::op_jsr, pcseq_pkg::op_jsl,
		pcseq_pkg::op_rti, pcseq_pkg::op_rts, pcseq_pkg::op_rtl,
		pcseq_pkg::op_jmp_ind, pcseq_pkg::op_jmp_indx, pcseq_pkg::op_jsr_indx:
			cls = pcseq_pkg::CLS_TRAP;
		pcseq_pkg::op_sep, pcseq_pkg::op_rep:
			cls = pcseq_pkg::CLS_MODE;
		pcseq_pkg::op_bpl, pcseq_pkg::op_bmi, pcseq_pkg::op_bvc,
		pcseq_pkg::op_bvs, pcseq_pkg::op_bcc, pcseq_pkg::op_bcs,
		pcseq_pkg::op_bne, pcseq_pkg::op_beq:
			cls = pcseq_pkg::CLS_BRANCH;
		pcseq_pkg::op_bra: begin
			cls = pcseq_pkg::CLS_BRANCH;
			cond = pcseq_pkg::COND_ALWAYS;
		end
		pcseq_pkg::op_brl:
			cls = pcseq_pkg::CLS_BRL;
		pcseq_pkg::op_jmp:
			cls = pcseq_pkg::CLS_JMP;
		pcseq_pkg::op_jml:
			cls = pcseq_pkg::CLS_JML;
		default:
			cls = (raw_inc == '0) ? pcseq_pkg::CLS_TRAP : pcseq_pkg::CLS_SEQ;
		endcase
	end

	// the strobe flag is the only control state here
	always_ff @(posedge clk) begin
		if (rst)
			d_valid <= 1'b0;
		else
			d_valid <= instr_valid;
	end

	// payload is captured on each strobe and otherwise left alone
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			d_class <= cls;
			d_cond <= cond;
			d_inc <= inc;
			d_operand <= operand;
			d_flag_n <= flag_n;
			d_flag_v <= flag_v;
			d_flag_z <= flag_z;
			d_flag_c <= flag_c;
		end
	end

endmodule

`default_nettype wire

/* rtl/pc_result.sv */
// result stage; PC changes only on retire, the 16-bit retire counter wraps silently
`timescale 1ns/1ps
`default_nettype none

module pc_result (
	input wire clk,
	input wire rst,
	input wire [pcseq_pkg::PC_W-1:0] next_pc,
	input wire does_retire,
	input wire does_trap,
	output logic [pcseq_pkg::PC_W-1:0] pc,
	output logic retire,
	output logic trap,
	output logic [15:0] retired_count
);

	// a trap leaves the PC where it is so the handler sees the faulting address
	always_ff @(posedge clk) begin
		if (rst)
			pc <= pcseq_pkg::RESET_PC;
		else if (does_retire)
			pc <= next_pc;
	end

	// one cycle pulses, lined up with the PC load
	always_ff @(posedge clk) begin
		if (rst) begin
			retire <= 1'b0;
			trap <= 1'b0;
		end else begin
			retire <= does_retire;
			trap <= does_trap;
		end
	end

	// traps are not counted
	always_ff @(posedge clk) begin
		if (rst)
			retired_count <= 16'd0;
		else if (does_retire)
			retired_count <= retired_count + 16'd1;
	end

endmodule

`default_nettype wire

/* rtl/pc_sequencer.sv */
// PC sequencer top; two instructions in flight at most, m_bit and x_bit are the forwarded values
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer (
	input wire clk,
	input wire rst,
	input wire instr_valid,
	input wire [7:0] opcode,
	input wire [pcseq_pkg::OPND_W-1:0] operand,
	input wire flag_n,
	input wire flag_v,
	input wire flag_z,
	input wire flag_c,
	input wire [3:0] suppress_pcinc,
	output logic [pcseq_pkg::PC_W-1:0] pc,
	output logic [pcseq_pkg::INC_W-1:0] inc,
	output logic m_bit,
	output logic x_bit,
	output logic retire,
	output logic trap,
	output logic [15:0] retired_count
);

	// decode to execute
	logic d_valid;
	logic [pcseq_pkg::CLS_W-1:0] d_class;
	logic [pcseq_pkg::COND_W-1:0] d_cond;
	logic [pcseq_pkg::INC_W-1:0] d_inc;
	logic [pcseq_pkg::OPND_W-1:0] d_operand;
	logic d_flag_n;
	logic d_flag_v;
	logic d_flag_z;
	logic d_flag_c;
	// execute to result
	logic [pcseq_pkg::PC_W-1:0] next_pc;
	logic does_retire;
	logic does_trap;

	opcode_decode u_decode (
		.clk(clk), .rst(rst), .instr_valid(instr_valid),
		.opcode(opcode), .operand(operand),
		.flag_n(flag_n), .flag_v(flag_v), .flag_z(flag_z), .flag_c(flag_c),
		.suppress_pcinc(suppress_pcinc), .m_bit(m_bit), .x_bit(x_bit),
		.inc(inc), .d_valid(d_valid), .d_class(d_class), .d_cond(d_cond),
		.d_inc(d_inc), .d_operand(d_operand),
		.d_flag_n(d_flag_n), .d_flag_v(d_flag_v), .d_flag_z(d_flag_z), .d_flag_c(d_flag_c)
	);

	// width bits loop back into decode for the next instruction's length
	flow_execute u_execute (
		.clk(clk), .rst(rst), .d_valid(d_valid), .d_class(d_class), .d_cond(d_cond),
		.d_inc(d_inc), .d_operand(d_operand),
		.d_flag_n(d_flag_n), .d_flag_v(d_flag_v), .d_flag_z(d_flag_z), .d_flag_c(d_flag_c),
		.pc(pc), .m_bit(m_bit), .x_bit(x_bit), .next_pc(next_pc),
		.does_retire(does_retire), .does_trap(does_trap)
	);

	pc_result u_result (
		.clk(clk), .rst(rst), .next_pc(next_pc),
		.does_retire(does_retire), .does_trap(does_trap),
		.pc(pc), .retire(retire), .trap(trap), .retired_count(retired_count)
	);

endmodule

`default_nettype wire

/* rtl/pcinc8.sv */
// instruction length table; length is 0 for PC-loading flow changes, unknown opcodes and suppression
`timescale 1ns/1ps
`default_nettype none

module pcinc8 (
	input wire [7:0] opcode,
	input wire [3:0] suppress_pcinc,
	input wire m_bit,
	input wire x_bit,
	output logic [pcseq_pkg::INC_W-1:0] inc
);

	// fully combinational, m_bit and x_bit only matter for the immediate groups
	always_comb begin
		inc = 4'd0;
		// any cleared suppression bit means fetch already stepped over the bytes
		if (suppress_pcinc == 4'hF) begin
			case (opcode)
			pcseq_pkg::op_sep, pcseq_pkg::op_rep:
				inc = 4'd2;
			// short branches carry one displacement byte
			pcseq_pkg::op_bpl, pcseq_pkg::op_bmi, pcseq_pkg::op_bvc,
			pcseq_pkg::op_bvs, pcseq_pkg::op_bcc, pcseq_pkg::op_bcs,
			pcseq_pkg::op_bne, pcseq_pkg::op_beq, pcseq_pkg::op_bra:
				inc = 4'd2;
			pcseq_pkg::op_brl:
				inc = 4'd3;
			pcseq_pkg::op_clc, pcseq_pkg::op_sec, pcseq_pkg::op_sei,
			pcseq_pkg::op_clv, pcseq_pkg::op_sed:
				inc = 4'd1;
			pcseq_pkg::op_tax, pcseq_pkg::op_txa, pcseq_pkg::op_tay,
			pcseq_pkg::op_tya:
				inc = 4'd1;
			pcseq_pkg::op_inx, pcseq_pkg::op_dex, pcseq_pkg::op_iny,
			pcseq_pkg::op_dey, pcseq_pkg::op_ina, pcseq_pkg::op_dea:
				inc = 4'd1;
			pcseq_pkg::op_nop, pcseq_pkg::op_stp, pcseq_pkg::op_wai:
				inc = 4'd1;
			// these load the PC themselves so nothing is added
			pcseq_pkg::op_brk, pcseq_pkg::op_jmp, pcseq_pkg::op_jml,
			pcseq_pkg::op_jmp_ind, pcseq_pkg::op_jmp_indx,
			pcseq_pkg::op_rts, pcseq_pkg::op_rtl, pcseq_pkg::op_rti,
			pcseq_pkg::op_jsr, pcseq_pkg::op_jsr_indx, pcseq_pkg::op_jsl:
				inc = 4'd0;
			// an 8-bit accumulator takes one immediate byte, 16-bit takes two
			pcseq_pkg::op_lda_imm, pcseq_pkg::op_adc_imm, pcseq_pkg::op_sbc_imm,
			pcseq_pkg::op_cmp_imm, pcseq_pkg::op_and_imm, pcseq_pkg::op_ora_imm,
			pcseq_pkg::op_eor_imm, pcseq_pkg::op_bit_imm:
				inc = m_bit ? 4'd2 : 4'd3;
			pcseq_pkg::op_ldx_imm, pcseq_pkg::op_ldy_imm, pcseq_pkg::op_cpx_imm,
			pcseq_pkg::op_cpy_imm:
				inc = x_bit ? 4'd2 : 4'd3;
			pcseq_pkg::op_lda_zp, pcseq_pkg::op_sta_zp:
				inc = 4'd2;
			pcseq_pkg::op_lda_abs, pcseq_pkg::op_sta_abs:
				inc = 4'd3;
			pcseq_pkg::op_asl_acc, pcseq_pkg::op_lsr_acc:
				inc = 4'd1;
			pcseq_pkg::op_pha, pcseq_pkg::op_pla, pcseq_pkg::op_phy,
			pcseq_pkg::op_ply:
				inc = 4'd1;
			// unimplemented opcode, decode turns this into a trap
			default:
				inc = 4'd0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/pcseq_pkg.sv */
// shared constants for the PC sequencer; only the 63 opcodes listed here are known, all others trap
`default_nettype none

package pcseq_pkg;

	// ==================================================
	// widths and reset state
	// ==================================================

	// the PC carries the program bank in bits 23:16
	localparam int PC_W = 24;
	// operand bytes, the byte after the opcode sits in bits 7:0
	localparam int OPND_W = 24;
	// instruction length code as produced by the length table
	localparam int INC_W = 4;
	localparam logic [PC_W-1:0] RESET_PC = 24'h00_E000;

	// ==================================================
	// instruction classes
	// ==================================================

	localparam int CLS_W = 3;
	localparam logic [CLS_W-1:0] CLS_SEQ = 3'd0;
	localparam logic [CLS_W-1:0] CLS_MODE = 3'd1;
	localparam logic [CLS_W-1:0] CLS_BRANCH = 3'd2;
	localparam logic [CLS_W-1:0] CLS_BRL = 3'd3;
	localparam logic [CLS_W-1:0] CLS_JMP = 3'd4;
	localparam logic [CLS_W-1:0] CLS_JML = 3'd5;
	localparam logic [CLS_W-1:0] CLS_TRAP = 3'd6;

	// branch condition select, the low three bits are opcode bits 7:5
	// bits 2:1 pick the flag (n, v, c, z) and bit 0 is the value that takes the branch
	localparam int COND_W = 4;
	// BRA shares opcode bits 7:5 with BCC, so it gets its own code
	localparam logic [COND_W-1:0] COND_ALWAYS = 4'b1000;

	// ==================================================
	// opcodes
	// ==================================================

	// flow changes that the sequencer cannot finish and hands off as traps
	localparam logic [7:0] op_brk = 8'h00;
	localparam logic [7:0] op_jsr = 8'h20;
	localparam logic [7:0] op_jsl = 8'h22;
	localparam logic [7:0] op_rti = 8'h40;
	localparam logic [7:0] op_rts = 8'h60;
	localparam logic [7:0] op_rtl = 8'h6B;
	localparam logic [7:0] op_jmp_ind = 8'h6C;
	localparam logic [7:0] op_jmp_indx = 8'h7C;
	localparam logic [7:0] op_jsr_indx = 8'hFC;
	// relative branches
	localparam logic [7:0] op_bpl = 8'h10;
	localparam logic [7:0] op_bmi = 8'h30;
	localparam logic [7:0] op_bvc = 8'h50;
	localparam logic [7:0] op_bvs = 8'h70;
	localparam logic [7:0] op_bra = 8'h80;
	localparam logic [7:0] op_brl = 8'h82;
	localparam logic [7:0] op_bcc = 8'h90;
	localparam logic [7:0] op_bcs = 8'hB0;
	localparam logic [7:0] op_bne = 8'hD0;
	localparam logic [7:0] op_beq = 8'hF0;
	// absolute jumps and the width mode changes
	localparam logic [7:0] op_jmp = 8'h4C;
	localparam logic [7:0] op_jml = 8'h5C;
	localparam logic [7:0] op_rep = 8'hC2;
	localparam logic [7:0] op_sep = 8'hE2;
	// single byte implied instructions
	localparam logic [7:0] op_clc = 8'h18;
	localparam logic [7:0] op_sec = 8'h38;
	localparam logic [7:0] op_sei = 8'h78;
	localparam logic [7:0] op_clv = 8'hB8;
	localparam logic [7:0] op_sed = 8'hF8;
	localparam logic [7:0] op_tax = 8'hAA;
	localparam logic [7:0] op_txa = 8'h8A;
	localparam logic [7:0] op_tay = 8'hA8;
	localparam logic [7:0] op_tya = 8'h98;
	localparam logic [7:0] op_inx = 8'hE8;
	localparam logic [7:0] op_dex = 8'hCA;
	localparam logic [7:0] op_iny = 8'hC8;
	localparam logic [7:0] op_dey = 8'h88;
	localparam logic [7:0] op_ina = 8'h1A;
	localparam logic [7:0] op_dea = 8'h3A;
	localparam logic [7:0] op_nop = 8'hEA;
	localparam logic [7:0] op_wai = 8'hCB;
	localparam logic [7:0] op_stp = 8'hDB;
	localparam logic [7:0] op_asl_acc = 8'h0A;
	localparam logic [7:0] op_lsr_acc = 8'h4A;
	localparam logic [7:0] op_pha = 8'h48;
	localparam logic [7:0] op_pla = 8'h68;
	localparam logic [7:0] op_phy = 8'h5A;
	localparam logic [7:0] op_ply = 8'h7A;
	// immediates sized by the m bit
	localparam logic [7:0] op_lda_imm = 8'hA9;
	localparam logic [7:0] op_adc_imm = 8'h69;
	localparam logic [7:0] op_sbc_imm = 8'hE9;
	localparam logic [7:0] op_cmp_imm = 8'hC9;
	localparam logic [7:0] op_and_imm = 8'h29;
	localparam logic [7:0] op_ora_imm = 8'h09;
	localparam logic [7:0] op_eor_imm = 8'h49;
	localparam logic [7:0] op_bit_imm = 8'h89;
	// immediates sized by the x bit
	localparam logic [7:0] op_ldx_imm = 8'hA2;
	localparam logic [7:0] op_ldy_imm = 8'hA0;
	localparam logic [7:0] op_cpx_imm = 8'hE0;
	localparam logic [7:0] op_cpy_imm = 8'hC0;
	// direct page and absolute memory operands
	localparam logic [7:0] op_lda_zp = 8'hA5;
	localparam logic [7:0] op_sta_zp = 8'h85;
	localparam logic [7:0] op_lda_abs = 8'hAD;
	localparam logic [7:0] op_sta_abs = 8'h8D;

endpackage

`default_nettype wire

/* src.f */
rtl/pcseq_pkg.sv
rtl/pcinc8.sv
rtl/opcode_decode.sv
rtl/flow_execute.sv
rtl/pc_result.sv
rtl/pc_sequencer.sv
verif/pc_sequencer_tb.sv

/* verif/pc_sequencer_tb.sv */
// random testbench; seed 85, inputs driven 5 ns after the rising edge, sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer_tb;

	localparam int RESET_CYCLES = 5;
	localparam int RUN_CYCLES = 2000;
	// a fifth more than the stimulus covers reset and the pipeline drain
	localparam int MAX_CYCLES = RUN_CYCLES + RUN_CYCLES / 5;

	// one expected result stage per driven cycle
	typedef struct packed {
		logic [23:0] pc;
		logic retire;
		logic trap;
		logic [15:0] count;
	} result_t;

	logic clk = 1'b0;
	logic rst;
	logic instr_valid;
	logic [7:0] opcode;
	logic [pcseq_pkg::OPND_W-1:0] operand;
	logic flag_n;
	logic flag_v;
	logic flag_z;
	logic flag_c;
	logic [3:0] suppress_pcinc;
	logic [pcseq_pkg::PC_W-1:0] pc;
	logic [pcseq_pkg::INC_W-1:0] inc;
	logic m_bit;
	logic x_bit;
	logic retire;
	logic trap;
	logic [15:0] retired_count;

	// reference state of the sequencer, updated in program order as each strobe is driven
	logic [23:0] model_pc;
	logic model_m;
	logic model_x;
	logic [15:0] model_count;
	logic [3:0] exp_inc;
	logic exp_m;
	logic exp_x;
	result_t pending[$];
	int errors = 0;
	int cycles = 0;

	// the last two entries are unknown opcodes, which have no length and trap
	logic [7:0] pool [0:31] = '{
		pcseq_pkg::op_nop, pcseq_pkg::op_clc, pcseq_pkg::op_tax, pcseq_pkg::op_inx,
		pcseq_pkg::op_pha, pcseq_pkg::op_lda_imm, pcseq_pkg::op_adc_imm, pcseq_pkg::op_cmp_imm,
		pcseq_pkg::op_ldx_imm, pcseq_pkg::op_cpy_imm, pcseq_pkg::op_lda_zp, pcseq_pkg::op_sta_abs,
		pcseq_pkg::op_sep, pcseq_pkg::op_rep, pcseq_pkg::op_bpl, pcseq_pkg::op_bmi,
		pcseq_pkg::op_bvc, pcseq_pkg::op_bvs, pcseq_pkg::op_bra, pcseq_pkg::op_bcc,
		pcseq_pkg::op_bcs, pcseq_pkg::op_bne, pcseq_pkg::op_beq, pcseq_pkg::op_brl,
		pcseq_pkg::op_jmp, pcseq_pkg::op_jml, pcseq_pkg::op_brk, pcseq_pkg::op_jsr,
		pcseq_pkg::op_rts, pcseq_pkg::op_jmp_ind, 8'h02, 8'h42
	};

	pc_sequencer uut (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .opcode(opcode), .operand(operand),
		.flag_n(flag_n), .flag_v(flag_v), .flag_z(flag_z), .flag_c(flag_c),
		.suppress_pcinc(suppress_pcinc), .pc(pc), .inc(inc), .m_bit(m_bit), .x_bit(x_bit),
		.retire(retire), .trap(trap), .retired_count(retired_count)
	);

	always #20 clk = ~clk;

	// ==================================================
	// reference model
	// ==================================================

	// instruction length in bytes, written out per pool opcode
	function automatic logic [3:0] length_of(input logic [7:0] op, input logic m,
			input logic x, input logic [3:0] sup);
		logic [3:0] len;
		case (op)
		pcseq_pkg::op_nop, pcseq_pkg::op_clc, pcseq_pkg::op_tax, pcseq_pkg::op_inx,
		pcseq_pkg::op_pha:
			len = 4'd1;
		pcseq_pkg::op_lda_imm, pcseq_pkg::op_adc_imm, pcseq_pkg::op_cmp_imm:
			len = m ? 4'd2 : 4'd3;
		pcseq_pkg::op_ldx_imm, pcseq_pkg::op_cpy_imm:
			len = x ? 4'd2 : 4'd3;
		pcseq_pkg::op_lda_zp, pcseq_pkg::op_sep, pcseq_pkg::op_rep,
		pcseq_pkg::op_bpl, pcseq_pkg::op_bmi, pcseq_pkg::op_bvc, pcseq_pkg::op_bvs,
		pcseq_pkg::op_bra, pcseq_pkg::op_bcc, pcseq_pkg::op_bcs, pcseq_pkg::op_bne,
		pcseq_pkg::op_beq:
			len = 4'd2;
		pcseq_pkg::op_sta_abs, pcseq_pkg::op_brl:
			len = 4'd3;
		// jmp, jml, jsr, brk, rts, the indirect jump and unknown opcodes
		default:
			len = 4'd0;
		endcase
		// the fetch unit has already stepped over the bytes
		if (sup != 4'hF)
			len = 4'd0;
		return len;
	endfunction

	function automatic logic branch_taken(input logic [7:0] op, input logic n, input logic v,
			input logic z, input logic c);
		case (op)
		pcseq_pkg::op_bpl: return !n;
		pcseq_pkg::op_bmi: return n;
		pcseq_pkg::op_bvc: return !v;
		pcseq_pkg::op_bvs: return v;
		pcseq_pkg::op_bcc: return !c;
		pcseq_pkg::op_bcs: return c;
		pcseq_pkg::op_bne: return !z;
		pcseq_pkg::op_beq: return z;
		default: return 1'b1;
		endcase
	endfunction

	function automatic logic is_trap(input logic [7:0] op);
		return op == pcseq_pkg::op_brk || op == pcseq_pkg::op_jsr || op == pcseq_pkg::op_rts
			|| op == pcseq_pkg::op_jmp_ind || op == 8'h02 || op == 8'h42;
	endfunction

	// predicts the current inc and width bits, then applies the driven instruction
	task automatic step_model();
		logic [3:0] len;
		logic [23:0] seq;
		result_t res;
		len = length_of(opcode, model_m, model_x, suppress_pcinc);
		exp_inc = len;
		exp_m = model_m;
		exp_x = model_x;
		res.retire = 1'b0;
		res.trap = 1'b0;
		if (instr_valid && is_trap(opcode)) begin
			res.trap = 1'b1;
		end else if (instr_valid) begin
			seq = model_pc + {20'd0, len};
			case (opcode)
			pcseq_pkg::op_jmp: model_pc = {model_pc[23:16], operand[15:0]};
			pcseq_pkg::op_jml: model_pc = operand;
			pcseq_pkg::op_brl: model_pc = seq + {{8{operand[15]}}, operand[15:0]};
			pcseq_pkg::op_bpl, pcseq_pkg::op_bmi, pcseq_pkg::op_bvc, pcseq_pkg::op_bvs,
			pcseq_pkg::op_bra, pcseq_pkg::op_bcc, pcseq_pkg::op_bcs, pcseq_pkg::op_bne,
			pcseq_pkg::op_beq:
				model_pc = branch_taken(opcode, flag_n, flag_v, flag_z, flag_c)
					? seq + {{16{operand[7]}}, operand[7:0]} : seq;
			default: model_pc = seq;
			endcase
			// SEP sets and REP clears the width bits picked by operand bits 5 and 4
			if (opcode == pcseq_pkg::op_sep) begin
				model_m = model_m | operand[5];
				model_x = model_x | operand[4];
			end else if (opcode == pcseq_pkg::op_rep) begin
				model_m = model_m & ~operand[5];
				model_x = model_x & ~operand[4];
			end
			model_count = model_count + 16'd1;
			res.retire = 1'b1;
		end
		res.pc = model_pc;
		res.count = model_count;
		pending.push_back(res);
	endtask

	// ==================================================
	// checks and stimulus
	// ==================================================

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	// one clock of random stimulus; results show up two cycles after their strobe
	task automatic run_cycle(input bit allow);
		result_t front;
		@(posedge clk);
		#5;
		instr_valid = allow && ($urandom % 4 != 0);
		opcode = pool[$urandom % 32];
		operand = 24'($urandom);
		flag_n = 1'($urandom);
		flag_v = 1'($urandom);
		flag_z = 1'($urandom);
		flag_c = 1'($urandom);
		suppress_pcinc = ($urandom % 8 == 0) ? 4'($urandom % 15) : 4'hF;
		step_model();
		@(negedge clk);
		check_value("inc", inc, exp_inc);
		check_value("m_bit", m_bit, exp_m);
		check_value("x_bit", x_bit, exp_x);
		front = pending.pop_front();
		check_value("pc", pc, front.pc);
		check_value("retire", retire, front.retire);
		check_value("trap", trap, front.trap);
		check_value("retired_count", retired_count, front.count);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run still going after %0d cycles, %0d errors so far",
				MAX_CYCLES, errors);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		result_t idle;
		void'($urandom(85));
		rst = 1'b1;
		instr_valid = 1'b0;
		opcode = pcseq_pkg::op_nop;
		operand = '0;
		flag_n = 1'b0;
		flag_v = 1'b0;
		flag_z = 1'b0;
		flag_c = 1'b0;
		suppress_pcinc = 4'hF;
		model_pc = pcseq_pkg::RESET_PC;
		model_m = 1'b1;
		model_x = 1'b1;
		model_count = 16'd0;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		rst = 1'b0;
		@(negedge clk);
		check_value("pc", pc, pcseq_pkg::RESET_PC);
		check_value("m_bit", m_bit, 1'b1);
		check_value("x_bit", x_bit, 1'b1);
		check_value("retire", retire, 1'b0);
		check_value("trap", trap, 1'b0);
		check_value("retired_count", retired_count, 16'd0);
		// nothing is in flight yet, so the first two results are the reset state
		idle = {pcseq_pkg::RESET_PC, 1'b0, 1'b0, 16'd0};
		pending.push_back(idle);
		pending.push_back(idle);
		repeat (RUN_CYCLES) run_cycle(1'b1);
		// two idle cycles drain the last strobes
		repeat (2) run_cycle(1'b0);
		$display("errors: %0d, retired instructions: %0d", errors, model_count);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
